// File: fp_format_pkg.sv
package fp_format_pkg;

  // binary32 field widths
  localparam int EXP_W  = 8;
  localparam int FRAC_W = 23;

  // all-ones exponent marks infinity or NaN
  localparam logic [EXP_W-1:0] EXP_MAX = 8'd255;

  // canonical quiet NaN returned for every invalid sum
  localparam logic [31:0] QNAN = 32'h7FC0_0000;

  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exp;
    logic [FRAC_W-1:0] frac;
  } fp_fields_t;

  // one word seen either as raw bits or as its fields
  typedef union packed {
    logic [31:0] raw;
    fp_fields_t  fields;
  } fp_word_t;

endpackage

// File: fp_stage_pkg.sv
package fp_stage_pkg;

  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } round_mode_t;

  // one operand after classification, hidden bit included
  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [23:0] mantissa;
    logic        is_zero;
    logic        is_subnormal;
    logic        is_inf;
    logic        is_nan;
  } fp_unpacked_t;

  // guard and round belong to the operand that was shifted
  typedef struct packed {
    logic [23:0] mant_a;
    logic [23:0] mant_b;
    logic [1:0]  guard_round;
    logic        sticky;
    logic [7:0]  exp_common;
  } fp_aligned_t;

  typedef struct packed {
    logic        sign;
    logic [24:0] mant_sum;
    logic [1:0]  guard_round;
    logic        sticky;
    logic [7:0]  exp_common;
  } fp_sum_t;

  // mant_ext is mantissa [26:3], guard [2], round [1], sticky [0]
  typedef struct packed {
    logic        sign;
    logic [7:0]  exp_out;
    logic [26:0] mant_ext;
  } fp_norm_t;

endpackage

// File: fp_unpack.sv
`timescale 1ns/10ps

module fp_unpack (
  input  fp_format_pkg::fp_word_t    operand,
  output fp_stage_pkg::fp_unpacked_t unp
);

  logic exp_zero;
  logic exp_max;
  logic frac_zero;
  logic mag_zero;

  assign exp_zero  = (operand.fields.exp == 8'd0);
  assign exp_max   = (operand.fields.exp == fp_format_pkg::EXP_MAX);
  assign frac_zero = (operand.fields.frac == 23'd0);

  // magnitude check on the raw word, sign bit ignored
  assign mag_zero = (operand.raw[30:0] == 31'd0);

  always_comb begin
    unp.sign = operand.fields.sign;

    // subnormals and zero behave as exponent 1 from here on
    if (exp_zero) begin
      unp.exponent = 8'd1;
    end else begin
      unp.exponent = operand.fields.exp;
    end

    // hidden bit only for normal numbers
    unp.mantissa = {!exp_zero && !exp_max, operand.fields.frac};

    unp.is_zero      = mag_zero;
    unp.is_subnormal = exp_zero && !frac_zero;
    unp.is_inf       = exp_max && frac_zero;
    unp.is_nan       = exp_max && !frac_zero;
  end

endmodule

// File: fp_align.sv
`timescale 1ns/10ps

module fp_align (
  input  fp_stage_pkg::fp_unpacked_t a,
  input  fp_stage_pkg::fp_unpacked_t b,
  output fp_stage_pkg::fp_aligned_t  aln
);

  logic        a_larger;
  logic [7:0]  diff;
  logic [23:0] small_mant;
  logic [49:0] shift_ext;
  logic [23:0] shifted;
  logic [1:0]  guard_round;
  logic        sticky;

  assign a_larger = (a.exponent >= b.exponent);
  assign diff = a_larger ? (a.exponent - b.exponent) : (b.exponent - a.exponent);
  assign small_mant = a_larger ? b.mantissa : a.mantissa;

  // 26 spare bits below the mantissa catch everything up to a shift of 26
  assign shift_ext = {small_mant, 26'd0} >> diff;

  always_comb begin
    if (diff > 8'd26) begin
      // whole operand lies below the sticky position
      shifted     = 24'd0;
      guard_round = 2'b00;
      sticky      = |small_mant;
    end else begin
      shifted     = shift_ext[49:26];
      guard_round = shift_ext[25:24];
      sticky      = |shift_ext[23:0];
    end
  end

  always_comb begin
    aln.exp_common  = a_larger ? a.exponent : b.exponent;
    aln.mant_a      = a_larger ? a.mantissa : shifted;
    aln.mant_b      = a_larger ? shifted : b.mantissa;
    aln.guard_round = guard_round;
    aln.sticky      = sticky;
  end

endmodule

// File: fp_add_mant.sv
`timescale 1ns/10ps

module fp_add_mant (
  input  logic                      sign_a,
  input  logic                      sign_b,
  input  fp_stage_pkg::fp_aligned_t aln,
  output fp_stage_pkg::fp_sum_t     sum
);

  logic        a_ge;
  logic [26:0] ext_big;
  logic [26:0] ext_small;
  logic [27:0] total;

  // a shifted mantissa is always the smaller one, so it owns the low bits
  assign a_ge      = (aln.mant_a >= aln.mant_b);
  assign ext_big   = a_ge ? {aln.mant_a, 3'b000} : {aln.mant_b, 3'b000};
  assign ext_small = a_ge ? {aln.mant_b, aln.guard_round, aln.sticky}
                          : {aln.mant_a, aln.guard_round, aln.sticky};

  always_comb begin
    if (sign_a == sign_b) begin
      total    = {1'b0, ext_big} + {1'b0, ext_small};
      sum.sign = sign_a;
    end else begin
      // sticky borrow ripples up through the low bits
      total    = {1'b0, ext_big} - {1'b0, ext_small};
      sum.sign = (total == 28'd0) ? 1'b0 : (a_ge ? sign_a : sign_b);
    end
    sum.mant_sum    = total[27:3];
    sum.guard_round = total[2:1];
    sum.sticky      = total[0];
    sum.exp_common  = aln.exp_common;
  end

endmodule

// File: fp_normalize.sv
`timescale 1ns/10ps

module fp_normalize (
  input  fp_stage_pkg::fp_sum_t  sum,
  output fp_stage_pkg::fp_norm_t norm
);

  logic [26:0] ext;
  logic [4:0]  lzc;
  logic        limited;
  logic [7:0]  shamt;

  assign ext = {sum.mant_sum[23:0], sum.guard_round, sum.sticky};

  // leading zeros of the extended sum, 27 when it is all zero
  always_comb begin
    lzc = 5'd27;
    for (int i = 0; i < 27; i++) begin
      if (ext[i]) begin
        lzc = 5'(26 - i);
      end
    end
  end

  // never shift below exponent 1, the result stays subnormal instead
  assign limited = ({3'b000, lzc} >= sum.exp_common);
  assign shamt   = limited ? (sum.exp_common - 8'd1) : {3'b000, lzc};

  always_comb begin
    norm.sign = sum.sign;
    if (sum.mant_sum[24]) begin
      // carry out, the lost bit becomes guard
      norm.exp_out  = sum.exp_common + 8'd1;
      norm.mant_ext = {sum.mant_sum, sum.guard_round[1],
                       sum.guard_round[0] | sum.sticky};
    end else if (ext == 27'd0) begin
      norm.exp_out  = 8'd0;
      norm.mant_ext = 27'd0;
    end else begin
      norm.mant_ext = ext << shamt;
      if (limited) begin
        norm.exp_out = 8'd0;
      end else begin
        norm.exp_out = sum.exp_common - {3'b000, lzc};
      end
    end
  end

endmodule

// File: fp_round_pack.sv
`timescale 1ns/10ps

module fp_round_pack (
  input  fp_stage_pkg::fp_norm_t     norm,
  input  fp_stage_pkg::round_mode_t  r_mode,
  input  fp_stage_pkg::fp_unpacked_t a,
  input  fp_stage_pkg::fp_unpacked_t b,
  output fp_format_pkg::fp_word_t    result,
  output logic                       overflow,
  output logic                       underflow
);

  logic [23:0] mant;
  logic        guard;
  logic        round_bit;
  logic        sticky;
  logic        inexact;
  logic        inc;
  logic [24:0] rounded;
  logic [8:0]  exp_r;
  logic [22:0] frac_r;
  logic        nan_res;

  assign mant      = norm.mant_ext[26:3];
  assign guard     = norm.mant_ext[2];
  assign round_bit = norm.mant_ext[1];
  assign sticky    = norm.mant_ext[0];
  assign inexact   = guard | round_bit | sticky;

  always_comb begin
    case (r_mode)
      fp_stage_pkg::RNE: inc = guard & (round_bit | sticky | mant[0]);
      fp_stage_pkg::RTZ: inc = 1'b0;
      fp_stage_pkg::RDN: inc = norm.sign & inexact;
      fp_stage_pkg::RUP: inc = !norm.sign & inexact;
      fp_stage_pkg::RMM: inc = guard;
      default:           inc = 1'b0;
    endcase
  end

  assign rounded = {1'b0, mant} + {24'd0, inc};

  // rounding carry, a subnormal reaching the hidden bit becomes normal
  always_comb begin
    if (rounded[24]) begin
      exp_r  = {1'b0, norm.exp_out} + 9'd1;
      frac_r = rounded[23:1];
    end else if ((norm.exp_out == 8'd0) && rounded[23]) begin
      exp_r  = 9'd1;
      frac_r = rounded[22:0];
    end else begin
      exp_r  = {1'b0, norm.exp_out};
      frac_r = rounded[22:0];
    end
  end

  assign nan_res = a.is_nan | b.is_nan | (a.is_inf & b.is_inf & (a.sign != b.sign));

  always_comb begin
    overflow  = 1'b0;
    underflow = 1'b0;
    if (nan_res) begin
      result.raw = fp_format_pkg::QNAN;
    end else if (a.is_inf) begin
      result.fields = '{sign: a.sign, exp: fp_format_pkg::EXP_MAX, frac: 23'd0};
    end else if (b.is_inf) begin
      result.fields = '{sign: b.sign, exp: fp_format_pkg::EXP_MAX, frac: 23'd0};
    end else if (exp_r >= {1'b0, fp_format_pkg::EXP_MAX}) begin
      overflow      = 1'b1;
      result.fields = '{sign: norm.sign, exp: fp_format_pkg::EXP_MAX, frac: 23'd0};
    end else begin
      underflow     = (exp_r == 9'd0) && (|norm.mant_ext);
      result.fields = '{sign: norm.sign, exp: exp_r[7:0], frac: frac_r};
    end
  end

endmodule

// File: fp_adder.sv
`timescale 1ns/10ps

module fp_adder (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  fp_format_pkg::fp_word_t   fp_a,
  input  fp_format_pkg::fp_word_t   fp_b,
  input  fp_stage_pkg::round_mode_t r_mode,
  output logic                      out_valid,
  output fp_format_pkg::fp_word_t   fp_result,
  output logic                      overflow,
  output logic                      underflow
);

  fp_stage_pkg::fp_unpacked_t unp_a;
  fp_stage_pkg::fp_unpacked_t unp_b;
  fp_stage_pkg::fp_aligned_t  aln;
  fp_stage_pkg::fp_sum_t      sum;
  fp_stage_pkg::fp_norm_t     norm;
  fp_format_pkg::fp_word_t    result_comb;
  logic                       ovf_comb;
  logic                       unf_comb;

  fp_unpack u_unpack_a (.operand(fp_a), .unp(unp_a));
  fp_unpack u_unpack_b (.operand(fp_b), .unp(unp_b));

  fp_align u_align (.a(unp_a), .b(unp_b), .aln(aln));

  fp_add_mant u_add_mant (
    .sign_a (unp_a.sign),
    .sign_b (unp_b.sign),
    .aln    (aln),
    .sum    (sum)
  );

  fp_normalize u_normalize (.sum(sum), .norm(norm));

  fp_round_pack u_round_pack (
    .norm      (norm),
    .r_mode    (r_mode),
    .a         (unp_a),
    .b         (unp_b),
    .result    (result_comb),
    .overflow  (ovf_comb),
    .underflow (unf_comb)
  );

  // single output stage, one cycle from in_valid to out_valid
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      fp_result <= '0;
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        fp_result <= result_comb;
        overflow  <= ovf_comb;
        underflow <= unf_comb;
      end
    end
  end

endmodule

// File: fp_adder_asserts.sv
`timescale 1ns/10ps

module fp_adder_asserts (
  input logic                       clk,
  input logic                       rst,
  input fp_format_pkg::fp_word_t    fp_a,
  input fp_format_pkg::fp_word_t    fp_b,
  input fp_stage_pkg::round_mode_t  r_mode,
  input fp_stage_pkg::fp_unpacked_t unp_a,
  input fp_stage_pkg::fp_unpacked_t unp_b,
  input fp_stage_pkg::fp_aligned_t  aln,
  input fp_stage_pkg::fp_sum_t      sum,
  input fp_stage_pkg::fp_norm_t     norm,
  input fp_format_pkg::fp_word_t    result_comb
);

  int          fail_count = 0;
  logic        special;
  logic        exact;
  logic [7:0]  exp_a;
  logic [7:0]  exp_b;
  logic [24:0] exact_sum;
  logic [30:0] trunc_word;

  assign special = unp_a.is_inf | unp_a.is_nan | unp_b.is_inf | unp_b.is_nan;
  assign exact   = (aln.guard_round == 2'b00) && !aln.sticky;

  // zero exponent field reads as 1 after unpacking
  assign exp_a = (fp_a.fields.exp == 8'd0) ? 8'd1 : fp_a.fields.exp;
  assign exp_b = (fp_b.fields.exp == 8'd0) ? 8'd1 : fp_b.fields.exp;

  // larger minus smaller when the signs differ
  assign exact_sum = (unp_a.sign == unp_b.sign) ? {1'b0, aln.mant_a} + {1'b0, aln.mant_b}
                   : (aln.mant_a >= aln.mant_b) ? {1'b0, aln.mant_a - aln.mant_b}
                   : {1'b0, aln.mant_b - aln.mant_a};

  // exponent and fraction without the hidden bit, before any increment
  assign trunc_word = {norm.exp_out, norm.mant_ext[25:3]};

  assert property (@(posedge clk) disable iff (rst)
    unp_a.sign == fp_a.fields.sign && unp_a.mantissa[22:0] == fp_a.fields.frac
    && unp_b.sign == fp_b.fields.sign && unp_b.mantissa[22:0] == fp_b.fields.frac
    && unp_a.exponent == exp_a && unp_b.exponent == exp_b)
    else begin
      $error("unpacked fields differ from the operand words");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst)
    aln.exp_common == ((unp_a.exponent > unp_b.exponent) ? unp_a.exponent : unp_b.exponent))
    else begin
      $error("exp_common is not the larger exponent");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst)
    exact |-> sum.mant_sum == exact_sum)
    else begin
      $error("mant_sum differs from the aligned sum or difference");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst)
    sum.mant_sum[24] |-> norm.exp_out == sum.exp_common + 8'd1)
    else begin
      $error("carry out of the sum did not raise the exponent");
      fail_count++;
    end

  // truncation keeps the normalized mantissa and exponent as they are
  assert property (@(posedge clk) disable iff (rst)
    (r_mode == fp_stage_pkg::RTZ && !special && norm.exp_out != 8'hFF)
    |-> result_comb.raw == {norm.sign, norm.exp_out, norm.mant_ext[25:3]})
    else begin
      $error("RTZ word is not sign, exponent and truncated mantissa");
      fail_count++;
    end

  // rounding adds at most one unit to exponent and fraction taken as one field
  assert property (@(posedge clk) disable iff (rst)
    (!special && result_comb.fields.exp != 8'hFF)
    |-> result_comb.fields.sign == norm.sign
        && (result_comb.raw[30:0] == trunc_word
            || ((|norm.mant_ext[2:0]) && result_comb.raw[30:0] == trunc_word + 31'd1)))
    else begin
      $error("packed word is not sign, exponent and rounded mantissa");
      fail_count++;
    end

endmodule

bind fp_adder fp_adder_asserts fp_adder_asserts_inst (.*);

// File: fp_adder_tb.sv
`timescale 1ns/10ps

module fp_adder_tb;

  // one table row, flags are {overflow, underflow}
  typedef struct packed {
    logic [31:0]               a;
    logic [31:0]               b;
    fp_stage_pkg::round_mode_t mode;
    logic [31:0]               result;
    logic [1:0]                flags;
  } vec_t;

  localparam fp_stage_pkg::round_mode_t RNE = fp_stage_pkg::RNE;
  localparam fp_stage_pkg::round_mode_t RTZ = fp_stage_pkg::RTZ;
  localparam fp_stage_pkg::round_mode_t RDN = fp_stage_pkg::RDN;
  localparam fp_stage_pkg::round_mode_t RUP = fp_stage_pkg::RUP;
  localparam fp_stage_pkg::round_mode_t RMM = fp_stage_pkg::RMM;

  logic                      clk;
  logic                      rst;
  logic                      in_valid;
  fp_format_pkg::fp_word_t   fp_a;
  fp_format_pkg::fp_word_t   fp_b;
  fp_stage_pkg::round_mode_t r_mode;
  logic                      out_valid;
  fp_format_pkg::fp_word_t   fp_result;
  logic                      overflow;
  logic                      underflow;
  vec_t                      table_q[$];
  string                     name_q[$];
  logic [31:0]               lfsr_state;
  int                        errors;
  int                        timeouts;
  int                        checks;

  fp_adder fp_adder_inst (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .fp_a      (fp_a),
    .fp_b      (fp_b),
    .r_mode    (r_mode),
    .out_valid (out_valid),
    .fp_result (fp_result),
    .overflow  (overflow),
    .underflow (underflow)
  );

  always #20 clk = ~clk;

  // galois LFSR, one step per bit, first bit taken ends up as msb
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return value;
  endfunction

  // exponent pulled into 1..254 so the word is a normal number
  function automatic logic [31:0] random_normal();
    logic [31:0] w;
    w = take_bits(32);
    if (w[30:23] == 8'h00) begin
      w[30:23] = 8'h01;
    end else if (w[30:23] == 8'hFF) begin
      w[30:23] = 8'hFE;
    end
    return w;
  endfunction

  function automatic void add_case(string name, logic [31:0] a, logic [31:0] b,
                                   fp_stage_pkg::round_mode_t mode, logic [31:0] res,
                                   logic [1:0] flags);
    table_q.push_back('{a: a, b: b, mode: mode, result: res, flags: flags});
    name_q.push_back(name);
  endfunction

  task automatic run_case(string name, vec_t v);
    int waited;
    @(posedge clk);
    in_valid <= 1'b1;
    fp_a     <= v.a;
    fp_b     <= v.b;
    r_mode   <= v.mode;
    @(posedge clk);
    in_valid <= 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!out_valid && waited < 10);
    if (!out_valid) begin
      $display("timeout: no out_valid within 10 cycles for %s", name);
      timeouts++;
    end else begin
      checks++;
      assert (fp_result.raw === v.result) else begin
        $display("CHECK FAILED %s: expected %08h actual %08h", name, v.result, fp_result.raw);
        errors++;
      end
      assert ({overflow, underflow} === v.flags) else begin
        $display("CHECK FAILED %s flags: expected %b actual %b", name, v.flags,
                 {overflow, underflow});
        errors++;
      end
    end
  endtask

  initial begin
    vec_t        v;
    logic [31:0] x;
    int          bound_fails;
    clk        = 1'b0;
    rst        = 1'b1;
    in_valid   = 1'b0;
    fp_a       = '0;
    fp_b       = '0;
    r_mode     = RNE;
    lfsr_state = 32'd10;
    errors     = 0;
    timeouts   = 0;
    checks     = 0;

    add_case("zero_zero", 32'h00000000, 32'h00000000, RNE, 32'h00000000, 2'b00);
    add_case("one_two", 32'h3F800000, 32'h40000000, RNE, 32'h40400000, 2'b00);
    add_case("sub_sub", 32'h000A0000, 32'h000A0000, RTZ, 32'h00140000, 2'b01);
    add_case("norm_sub", 32'h01000000, 32'h00300000, RTZ, 32'h01180000, 2'b00);
    // 23-bit gap leaves guard 0, round 1, sticky 1
    add_case("gap_rtz", 32'h14300000, 32'h1FC00000, RTZ, 32'h1FC00001, 2'b00);
    add_case("gap_rup", 32'h14300000, 32'h1FC00000, RUP, 32'h1FC00002, 2'b00);
    add_case("gap_rdn", 32'h14300000, 32'h1FC00000, RDN, 32'h1FC00001, 2'b00);
    add_case("pos_rne", 32'h3F800000, 32'h33C00000, RNE, 32'h3F800001, 2'b00);
    add_case("pos_rtz", 32'h3F800000, 32'h33C00000, RTZ, 32'h3F800000, 2'b00);
    add_case("pos_rdn", 32'h3F800000, 32'h33C00000, RDN, 32'h3F800000, 2'b00);
    add_case("pos_rup", 32'h3F800000, 32'h33C00000, RUP, 32'h3F800001, 2'b00);
    add_case("pos_rmm", 32'h3F800000, 32'h33C00000, RMM, 32'h3F800001, 2'b00);
    add_case("neg_rne", 32'hBF800000, 32'hB3C00000, RNE, 32'hBF800001, 2'b00);
    add_case("neg_rtz", 32'hBF800000, 32'hB3C00000, RTZ, 32'hBF800000, 2'b00);
    add_case("neg_rdn", 32'hBF800000, 32'hB3C00000, RDN, 32'hBF800001, 2'b00);
    add_case("neg_rup", 32'hBF800000, 32'hB3C00000, RUP, 32'hBF800000, 2'b00);
    add_case("neg_rmm", 32'hBF800000, 32'hB3C00000, RMM, 32'hBF800001, 2'b00);
    // exact half ulp, even lsb stays for RNE
    add_case("tie_rne", 32'h3F800000, 32'h33800000, RNE, 32'h3F800000, 2'b00);
    add_case("tie_rmm", 32'h3F800000, 32'h33800000, RMM, 32'h3F800001, 2'b00);
    add_case("overflow", 32'h7F7FFFFF, 32'h7F7FFFFF, RNE, 32'h7F800000, 2'b10);
    add_case("underflow", 32'h00800000, 32'h80700000, RNE, 32'h00100000, 2'b01);
    add_case("qnan_a", 32'h7FC00000, 32'h3F800000, RNE, 32'h7FC00000, 2'b00);
    add_case("snan_b", 32'h3F800000, 32'h7F800001, RUP, 32'h7FC00000, 2'b00);
    add_case("inf_minus_inf", 32'h7F800000, 32'hFF800000, RNE, 32'h7FC00000, 2'b00);
    add_case("inf_plus_fin", 32'h7F800000, 32'hC2280000, RNE, 32'h7F800000, 2'b00);
    add_case("fin_plus_ninf", 32'h40490FDB, 32'hFF800000, RTZ, 32'hFF800000, 2'b00);

    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (!out_valid && fp_result.raw == 32'd0 && !overflow && !underflow) else begin
      $display("CHECK FAILED reset: expected 0 0 00000000 actual %b %b%b %08h", out_valid,
               overflow, underflow, fp_result.raw);
      errors++;
    end

    foreach (table_q[i]) begin
      run_case(name_q[i], table_q[i]);
    end

    for (int i = 0; i < 8; i++) begin
      x = random_normal();
      for (int m = 0; m < 5; m++) begin
        v = '{a: x, b: x ^ 32'h8000_0000, mode: fp_stage_pkg::round_mode_t'(m),
              result: '0, flags: 2'b00};
        run_case($sformatf("cancel_%0d_mode%0d", i, m), v);
      end
      v = '{a: x, b: 32'h0, mode: RNE, result: x, flags: 2'b00};
      run_case($sformatf("plus_zero_%0d", i), v);
    end

    bound_fails = fp_adder_inst.fp_adder_asserts_inst.fail_count;
    $display("checks %0d, errors %0d, timeouts %0d, bound assertion failures %0d",
             checks, errors, timeouts, bound_fails);
    if (errors == 0 && timeouts == 0 && bound_fails == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
fp_format_pkg.sv
fp_stage_pkg.sv
fp_unpack.sv
fp_align.sv
fp_add_mant.sv
fp_normalize.sv
fp_round_pack.sv
fp_adder.sv
fp_adder_asserts.sv
fp_adder_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = fp_adder_tb
FILELIST  = tb.f
PASS_MSG  = Result: PASSED

SOURCES   = $(shell grep -v '^+' $(FILELIST))
SIM       = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
